// ==== logic/ulaTimingPkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////
// Raster geometry and display window
////////////////////////////////////////////////////////////

package ulaTimingPkg;

   // Pixel column within a line
   typedef logic [8:0] hCount_t;

   // Line number within a frame
   typedef logic [8:0] vCount_t;

   // 48K style frame, 7 MHz pixel clock
   localparam int DefaultLineLength = 448;
   localparam int DefaultFrameLines = 312;

   // Paper area in pixels and lines
   localparam int PaperWidth = 256;
   localparam int PaperHeight = 192;

   // Fetch runs one character cell ahead of the display
   localparam int FetchLead = 8;

   // Interrupt line, also where the flash counter ticks
   localparam vCount_t IntLine = 9'd248;

   // 64 pixel clocks, i.e. 32 T-states of INT
   localparam hCount_t IntStart = 9'd2;
   localparam hCount_t IntEnd = 9'd65;

   // Horizontal sync columns
   localparam hCount_t HsyncStart = 9'd320;
   localparam hCount_t HsyncEnd = 9'd351;

   // Vertical sync lines
   localparam vCount_t VsyncStart = 9'd248;
   localparam vCount_t VsyncEnd = 9'd251;

endpackage

`default_nettype wire

// ==== logic/ulaBusPkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////
// CPU side and colour types
////////////////////////////////////////////////////////////

package ulaBusPkg;

   // Z80 I/O cycle as seen by the ULA
   typedef struct packed {
      logic [15:0] addr;
      logic iorqN;
      logic rdN;
      logic wrN;
      logic [7:0] data;
   } cpuBus_t;

   // Port 0xFE answers whenever A0 is low
   localparam int UlaPortMaskBit = 0;

   // ULAplus register select and data ports
   localparam logic [15:0] PlusAddrPort = 16'hBF3B;
   localparam logic [15:0] PlusDataPort = 16'hFF3B;

   // Classic attribute layout
   typedef struct packed {
      logic flash;
      logic bright;
      logic [2:0] paper;
      logic [2:0] ink;
   } attrClassic_t;

   // ULAplus reuses flash and bright as palette group
   typedef struct packed {
      logic [1:0] group;
      logic [2:0] paper;
      logic [2:0] ink;
   } attrPlus_t;

   typedef union packed {
      attrClassic_t classic;
      attrPlus_t plus;
   } attr_u;

   // One palette RAM write, value is GGGRRRBB
   typedef struct packed {
      logic we;
      logic [5:0] index;
      logic [7:0] value;
   } paletteWrite_t;

   // 9-bit output colour
   typedef struct packed {
      logic [2:0] g;
      logic [2:0] r;
      logic [2:0] b;
   } rgb_t;

endpackage

`default_nettype wire

// ==== logic/rasterCounter.sv ====
`default_nettype none

module rasterCounter #(
   parameter int lineLength = ulaTimingPkg::DefaultLineLength,
   parameter int frameLines = ulaTimingPkg::DefaultFrameLines
) (
   input wire clk7,
   input wire rst_n,
   output ulaTimingPkg::hCount_t hc,
   output ulaTimingPkg::vCount_t vc,
   output logic csync,
   output logic intN
);

   logic lineEnd;
   logic frameEnd;
   logic hsync;
   logic vsync;

   // Last column and last line of the frame
   assign lineEnd = hc == ulaTimingPkg::hCount_t'(lineLength - 1);
   assign frameEnd = vc == ulaTimingPkg::vCount_t'(frameLines - 1);

   ////////////////////////////////////////////////////////////
   // Counters
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         hc <= '0;
         vc <= '0;
      end else if (lineEnd) begin
         hc <= '0;
         // Line count steps on the horizontal wrap
         if (frameEnd) begin
            vc <= '0;
         end else begin
            vc <= vc + 1'b1;
         end
      end else begin
         hc <= hc + 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////
   // Sync and interrupt decode
   ////////////////////////////////////////////////////////////

   assign hsync = hc >= ulaTimingPkg::HsyncStart && hc <= ulaTimingPkg::HsyncEnd;
   assign vsync = vc >= ulaTimingPkg::VsyncStart && vc <= ulaTimingPkg::VsyncEnd;

   // Low on hsync, polarity flipped over the vsync lines
   assign csync = ~(hsync ^ vsync);

   // INT window at the start of the interrupt line
   assign intN = !(vc == ulaTimingPkg::IntLine &&
                   hc >= ulaTimingPkg::IntStart &&
                   hc <= ulaTimingPkg::IntEnd);

endmodule

`default_nettype wire

// ==== logic/ioPorts.sv ====
`default_nettype none

module ioPorts (
   input wire clk7,
   input wire rst_n,
   input wire ulaBusPkg::cpuBus_t bus,
   input wire ear,
   input wire [4:0] kbd,
   input wire issue2Keyboard,
   input wire [7:0] paletteEntry,
   output logic [7:0] dout,
   output logic mic,
   output logic spk,
   output logic [2:0] border,
   output logic plusEnable,
   output logic [5:0] paletteIndex,
   output ulaBusPkg::paletteWrite_t paletteWrite
);

   // Border comes up red
   localparam logic [2:0] ResetBorder = 3'd2;

   logic ioWrite;
   logic ioRead;
   logic ulaSel;
   logic plusAddrSel;
   logic plusDataSel;
   logic plusMode;
   logic [6:0] plusReg;
   logic procEar;

   ////////////////////////////////////////////////////////////
   // Address decode
   ////////////////////////////////////////////////////////////

   // Z80 strobes, both active low
   assign ioWrite = !bus.iorqN && !bus.wrN;
   assign ioRead = !bus.iorqN && !bus.rdN;

   // Partial decode on A0
   assign ulaSel = !bus.addr[ulaBusPkg::UlaPortMaskBit];
   assign plusAddrSel = bus.addr == ulaBusPkg::PlusAddrPort;
   assign plusDataSel = bus.addr == ulaBusPkg::PlusDataPort;

   // Bit 6 of the register selects config group, low bits the index
   assign plusMode = plusReg[6];
   assign paletteIndex = plusReg[5:0];

   ////////////////////////////////////////////////////////////
   // Port writes
   ////////////////////////////////////////////////////////////

   // Port 0xFE
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         border <= ResetBorder;
         mic <= 1'b0;
         spk <= 1'b0;
      end else if (ioWrite && ulaSel) begin
         border <= bus.data[2:0];
         mic <= bus.data[3];
         spk <= bus.data[4];
      end
   end

   // ULAplus register and config bit
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         plusReg <= '0;
         plusEnable <= 1'b0;
      end else if (ioWrite && !ulaSel) begin
         if (plusAddrSel) begin
            plusReg <= bus.data[6:0];
         end else if (plusDataSel && plusMode) begin
            plusEnable <= bus.data[0];
         end
      end
   end

   // Palette RAM write, index from the register
   always_comb begin
      paletteWrite.we = ioWrite && !ulaSel && plusDataSel && !plusMode;
      paletteWrite.index = plusReg[5:0];
      paletteWrite.value = bus.data;
   end

   ////////////////////////////////////////////////////////////
   // Read mux
   ////////////////////////////////////////////////////////////

   // Issue 2 boards also leak MIC onto the EAR input
   assign procEar = issue2Keyboard ? (ear ^ (spk | mic)) : (ear ^ spk);

   always_comb begin
      dout = 8'hFF;
      if (ioRead) begin
         if (ulaSel) begin
            dout = {1'b1, procEar, 1'b1, kbd};
         end else if (plusAddrSel) begin
            dout = {1'b0, plusReg};
         end else if (plusDataSel && !plusMode) begin
            dout = paletteEntry;
         end else if (plusDataSel && plusMode) begin
            dout = {7'b0000000, plusEnable};
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/videoFetch.sv ====
`default_nettype none

module videoFetch (
   input wire clk7,
   input wire rst_n,
   input wire ulaTimingPkg::hCount_t hc,
   input wire ulaTimingPkg::vCount_t vc,
   input wire [2:0] border,
   input wire [7:0] vramData,
   output logic [13:0] va,
   output ulaBusPkg::attr_u attrNext,
   output logic attrLoad,
   output ulaBusPkg::attr_u attr,
   output logic pixel
);

   logic fetchWindow;
   logic videoEnable;
   logic columnLoad;
   logic bitmapLoad;
   logic attrDataLoad;
   logic serializerLoad;
   logic [4:0] column;
   logic [7:0] bitmapData;
   logic [7:0] attrData;
   logic [7:0] shiftReg;
   logic [4:0] flashCount;
   logic flashPhase;

   ////////////////////////////////////////////////////////////
   // Fetch sequencer
   ////////////////////////////////////////////////////////////

   // VRAM reads cover the paper columns
   assign fetchWindow = hc < ulaTimingPkg::PaperWidth && vc < ulaTimingPkg::PaperHeight;

   // Display lags the fetch by one cell
   assign videoEnable = hc >= ulaTimingPkg::FetchLead &&
                        hc < ulaTimingPkg::PaperWidth + ulaTimingPkg::FetchLead &&
                        vc < ulaTimingPkg::PaperHeight;

   // Column latched just ahead of each fetch pair
   assign columnLoad = hc[2:0] == 3'd3;

   // Upper half of each 16 clocks fetches two cells
   // bitmap at 8/12, latch 9/13; attribute at 10/14, latch 11/15
   assign bitmapLoad = fetchWindow && hc[3] && !hc[1] && hc[0];
   assign attrDataLoad = fetchWindow && hc[3] && hc[1] && hc[0];

   // Output stage reloads every 8 pixels
   assign attrLoad = hc[2:0] == 3'd4;
   assign serializerLoad = videoEnable && attrLoad;

   // Bitmap uses the thirds layout, attributes sit at 0x1800
   always_comb begin
      if (hc[1]) begin
         va = {1'b0, 3'b110, vc[7:3], column};
      end else begin
         va = {1'b0, vc[7:6], vc[2:0], vc[5:3], column};
      end
   end

   ////////////////////////////////////////////////////////////
   // Data latches
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk7) begin
      if (columnLoad) begin
         column <= hc[7:3];
      end
   end

   always_ff @(posedge clk7) begin
      if (bitmapLoad) begin
         bitmapData <= vramData;
      end
      if (attrDataLoad) begin
         attrData <= vramData;
      end
   end

   // Border cells: paper from the border latch, no flash or bright
   always_comb begin
      if (videoEnable) begin
         attrNext = attrData;
      end else begin
         attrNext = '0;
         attrNext.classic.paper = border;
      end
   end

   always_ff @(posedge clk7) begin
      if (attrLoad) begin
         attr <= attrNext;
      end
   end

   ////////////////////////////////////////////////////////////
   // Serializer and flash
   ////////////////////////////////////////////////////////////

   // MSB first, zeros shift in over the border
   always_ff @(posedge clk7) begin
      if (serializerLoad) begin
         shiftReg <= bitmapData;
      end else begin
         shiftReg <= {shiftReg[6:0], 1'b0};
      end
   end

   // One tick per frame, phase flips every 16 frames
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         flashCount <= '0;
      end else if (vc == ulaTimingPkg::IntLine && hc == '0) begin
         flashCount <= flashCount + 5'd1;
      end
   end

   assign flashPhase = flashCount[4];
   assign pixel = shiftReg[7] ^ (attr.classic.flash & flashPhase);

endmodule

`default_nettype wire

// ==== logic/colourMapper.sv ====
`default_nettype none

module colourMapper (
   input wire clk7,
   input wire rst_n,
   input wire ulaBusPkg::attr_u attrNext,
   input wire attrLoad,
   input wire ulaBusPkg::attr_u attr,
   input wire pixel,
   input wire plusEnable,
   input wire ulaBusPkg::paletteWrite_t paletteWrite,
   input wire [5:0] paletteIndex,
   output logic [7:0] paletteEntry,
   output ulaBusPkg::rgb_t rgb
);

   // Gun levels for the standard palette
   localparam logic [2:0] LevelOff = 3'b000;
   localparam logic [2:0] LevelHalf = 3'b101;
   localparam logic [2:0] LevelFull = 3'b111;

   logic [7:0] paletteRam [64];
   logic [5:0] paperIndex;
   logic [5:0] inkIndex;
   logic [7:0] plusPaper;
   logic [7:0] plusInk;
   logic [7:0] plusColour;
   logic [3:0] stdColour;
   ulaBusPkg::rgb_t stdRgb;
   ulaBusPkg::rgb_t plusRgb;

   ////////////////////////////////////////////////////////////
   // Standard IGRB path
   ////////////////////////////////////////////////////////////

   assign stdColour = {attr.classic.bright, pixel ? attr.classic.ink : attr.classic.paper};

   // IGRB to GGGRRRBBB, black is the same at both brightness levels
   always_comb begin
      case (stdColour)
         4'd1: stdRgb = {LevelOff, LevelOff, LevelHalf};
         4'd2: stdRgb = {LevelOff, LevelHalf, LevelOff};
         4'd3: stdRgb = {LevelOff, LevelHalf, LevelHalf};
         4'd4: stdRgb = {LevelHalf, LevelOff, LevelOff};
         4'd5: stdRgb = {LevelHalf, LevelOff, LevelHalf};
         4'd6: stdRgb = {LevelHalf, LevelHalf, LevelOff};
         4'd7: stdRgb = {LevelHalf, LevelHalf, LevelHalf};
         4'd9: stdRgb = {LevelOff, LevelOff, LevelFull};
         4'd10: stdRgb = {LevelOff, LevelFull, LevelOff};
         4'd11: stdRgb = {LevelOff, LevelFull, LevelFull};
         4'd12: stdRgb = {LevelFull, LevelOff, LevelOff};
         4'd13: stdRgb = {LevelFull, LevelOff, LevelFull};
         4'd14: stdRgb = {LevelFull, LevelFull, LevelOff};
         4'd15: stdRgb = {LevelFull, LevelFull, LevelFull};
         default: stdRgb = {LevelOff, LevelOff, LevelOff};
      endcase
   end

   ////////////////////////////////////////////////////////////
   // ULAplus palette path
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk7) begin
      if (paletteWrite.we) begin
         paletteRam[paletteWrite.index] <= paletteWrite.value;
      end
   end

   // CPU readback port
   assign paletteEntry = paletteRam[paletteIndex];

   // Paper entries live in the upper half of each group
   assign paperIndex = {attrNext.plus.group, 1'b1, attrNext.plus.paper};
   assign inkIndex = {attrNext.plus.group, 1'b0, attrNext.plus.ink};

   // Both colours of the next cell, captured with the attribute
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         plusPaper <= '0;
         plusInk <= '0;
      end else if (attrLoad) begin
         plusPaper <= paletteRam[paperIndex];
         plusInk <= paletteRam[inkIndex];
      end
   end

   assign plusColour = pixel ? plusInk : plusPaper;

   // Blue B1 B0 widened to B1 B0 B1
   assign plusRgb = {plusColour, plusColour[1]};

   assign rgb = plusEnable ? plusRgb : stdRgb;

endmodule

`default_nettype wire

// ==== logic/ulaCore.sv ====
`default_nettype none

module ulaCore #(
   parameter int lineLength = ulaTimingPkg::DefaultLineLength,
   parameter int frameLines = ulaTimingPkg::DefaultFrameLines
) (
   input wire clk7,
   input wire rst_n,
   input wire ulaBusPkg::cpuBus_t bus,
   input wire [7:0] vramData,
   output logic [13:0] va,
   input wire ear,
   input wire [4:0] kbd,
   input wire issue2Keyboard,
   output logic [7:0] dout,
   output logic mic,
   output logic spk,
   output logic intN,
   output logic csync,
   output ulaBusPkg::rgb_t rgb
);

   ulaTimingPkg::hCount_t hc;
   ulaTimingPkg::vCount_t vc;
   logic [2:0] border;
   logic plusEnable;
   logic [5:0] paletteIndex;
   logic [7:0] paletteEntry;
   ulaBusPkg::paletteWrite_t paletteWrite;
   ulaBusPkg::attr_u attrNext;
   ulaBusPkg::attr_u attr;
   logic attrLoad;
   logic pixel;

   ////////////////////////////////////////////////////////////
   // Raster timing
   ////////////////////////////////////////////////////////////

   rasterCounter #(
      .lineLength(lineLength),
      .frameLines(frameLines)
   ) u_rasterCounter (
      .clk7(clk7),
      .rst_n(rst_n),
      .hc(hc),
      .vc(vc),
      .csync(csync),
      .intN(intN)
   );

   // CPU ports, border and ULAplus registers
   ioPorts u_ioPorts (
      .clk7(clk7),
      .rst_n(rst_n),
      .bus(bus),
      .ear(ear),
      .kbd(kbd),
      .issue2Keyboard(issue2Keyboard),
      .paletteEntry(paletteEntry),
      .dout(dout),
      .mic(mic),
      .spk(spk),
      .border(border),
      .plusEnable(plusEnable),
      .paletteIndex(paletteIndex),
      .paletteWrite(paletteWrite)
   );

   // Screen fetch and pixel stream
   videoFetch u_videoFetch (
      .clk7(clk7),
      .rst_n(rst_n),
      .hc(hc),
      .vc(vc),
      .border(border),
      .vramData(vramData),
      .va(va),
      .attrNext(attrNext),
      .attrLoad(attrLoad),
      .attr(attr),
      .pixel(pixel)
   );

   // Palette lookup to 9-bit colour
   colourMapper u_colourMapper (
      .clk7(clk7),
      .rst_n(rst_n),
      .attrNext(attrNext),
      .attrLoad(attrLoad),
      .attr(attr),
      .pixel(pixel),
      .plusEnable(plusEnable),
      .paletteWrite(paletteWrite),
      .paletteIndex(paletteIndex),
      .paletteEntry(paletteEntry),
      .rgb(rgb)
   );

endmodule

`default_nettype wire

// ==== test/ulaTb.sv ====
`default_nettype none

module ulaTb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int LineLength = 448;
   localparam int FrameLines = 312;
   localparam int ClkPeriod = 100;
   localparam longint FrameCycles = LineLength * FrameLines;
   // Last pixel checks fall early in frame 16
   localparam longint WatchdogCycles = 17 * FrameCycles + 1000;

   localparam logic [15:0] PlusAddr = 16'hBF3B;
   localparam logic [15:0] PlusData = 16'hFF3B;
   localparam int IntLine = 248;
   localparam int IntStart = 2;
   localparam int IntEnd = 65;
   localparam int HsyncStart = 320;
   localparam int HsyncEnd = 351;
   localparam int VsyncStart = 248;
   localparam int VsyncEnd = 251;

   typedef enum logic [1:0] {OpWrite, OpRead, OpPixel, OpInterrupt} op_e;

   // Frame, line and col only matter for pixel rows
   typedef struct packed {
      op_e op;
      logic [15:0] addr;
      logic [7:0] data;
      logic [4:0] kbd;
      logic ear;
      logic issue2;
      logic [4:0] frame;
      logic [8:0] line;
      logic [8:0] col;
      logic [8:0] expected;
   } row_t;

   logic clk7;
   logic rst_n;
   ulaBusPkg::cpuBus_t bus;
   logic [7:0] vramData;
   logic [13:0] va;
   logic ear;
   logic [4:0] kbd;
   logic issue2Keyboard;
   logic [7:0] dout;
   logic mic;
   logic spk;
   logic intN;
   logic csync;
   ulaBusPkg::rgb_t rgb;

   row_t stimulus[$];
   logic [7:0] palModel [64];
   int seed;
   int rasterHc;
   int rasterVc;
   int frameCount;
   int rowErrors;
   int passCount;
   int failCount;

   ulaCore #(
      .lineLength(LineLength),
      .frameLines(FrameLines)
   ) u_ulaCore (
      .clk7(clk7),
      .rst_n(rst_n),
      .bus(bus),
      .vramData(vramData),
      .va(va),
      .ear(ear),
      .kbd(kbd),
      .issue2Keyboard(issue2Keyboard),
      .dout(dout),
      .mic(mic),
      .spk(spk),
      .intN(intN),
      .csync(csync),
      .rgb(rgb)
   );

   always #(ClkPeriod / 2) clk7 = ~clk7;

   ////////////////////////////////////////////////////////////
   // VRAM model and reference colours
   ////////////////////////////////////////////////////////////

   // Attribute per column with flash cells at 4, 8, 12 and 15
   function automatic logic [7:0] attrByte(input logic [3:0] column);
      case (column)
         4'd0: return 8'h38;
         4'd1: return 8'h47;
         4'd2: return 8'h16;
         4'd3: return 8'h61;
         4'd4: return 8'hB9;
         4'd5: return 8'h2C;
         4'd6: return 8'h55;
         4'd7: return 8'h0A;
         4'd8: return 8'hFA;
         4'd9: return 8'h13;
         4'd10: return 8'h68;
         4'd11: return 8'h24;
         4'd12: return 8'hC5;
         4'd13: return 8'h3E;
         4'd14: return 8'h71;
         default: return 8'h8F;
      endcase
   endfunction

   // Attribute area starts at 0x1800
   function automatic logic [7:0] vramByte(input logic [13:0] addr);
      if (addr[13:11] == 3'b011) begin
         return attrByte(addr[3:0]);
      end
      return addr[7:0] ^ 8'h5A;
   endfunction

   assign vramData = vramByte(va);

   // Each set IGRB gun at 5 or 7 depending on bright
   function automatic ulaBusPkg::rgb_t stdColour(input logic bright, input logic [2:0] grb);
      logic [2:0] level;
      ulaBusPkg::rgb_t colour;
      level = bright ? 3'b111 : 3'b101;
      colour.g = grb[2] ? level : 3'b000;
      colour.r = grb[1] ? level : 3'b000;
      colour.b = grb[0] ? level : 3'b000;
      return colour;
   endfunction

   function automatic ulaBusPkg::rgb_t expectPixel(input logic [8:0] y, input logic [8:0] x,
                                                   input logic plus, input int frame);
      logic [13:0] bitmapAddr;
      logic [13:0] attrAddr;
      logic [7:0] bitmap;
      logic [7:0] attr;
      logic ink;
      logic [5:0] index;
      logic [7:0] value;
      // Thirds layout for the bitmap
      bitmapAddr = {1'b0, y[7:6], y[2:0], y[5:3], x[7:3]};
      attrAddr = 14'h1800 + {y[7:3], x[7:3]};
      bitmap = vramByte(bitmapAddr);
      attr = vramByte(attrAddr);
      // Flash counter bit 4 flips every 16 frames
      ink = bitmap[3'd7 - x[2:0]] ^ (attr[7] & frame[4]);
      if (plus) begin
         index = ink ? {attr[7:6], 1'b0, attr[2:0]} : {attr[7:6], 1'b1, attr[5:3]};
         value = palModel[index];
         return {value, value[1]};
      end
      return stdColour(attr[6], ink ? attr[2:0] : attr[5:3]);
   endfunction

   // Own raster count from reset release
   always @(posedge clk7) begin
      if (!rst_n) begin
         rasterHc <= 0;
         rasterVc <= 0;
         frameCount <= 0;
      end else if (rasterHc == LineLength - 1) begin
         rasterHc <= 0;
         if (rasterVc == FrameLines - 1) begin
            rasterVc <= 0;
            frameCount <= frameCount + 1;
         end else begin
            rasterVc <= rasterVc + 1;
         end
      end else begin
         rasterHc <= rasterHc + 1;
      end
   end

   ////////////////////////////////////////////////////////////
   // Table construction
   ////////////////////////////////////////////////////////////

   task automatic writeRow(input logic [15:0] addr, input logic [7:0] data,
                           input logic [8:0] expected);
      row_t row;
      row = '0;
      row.op = OpWrite;
      row.addr = addr;
      row.data = data;
      row.expected = expected;
      stimulus.push_back(row);
   endtask

   task automatic readRow(input logic [15:0] addr, input logic [4:0] kbdValue,
                          input logic earValue, input logic issue2, input logic [7:0] expected);
      row_t row;
      row = '0;
      row.op = OpRead;
      row.addr = addr;
      row.kbd = kbdValue;
      row.ear = earValue;
      row.issue2 = issue2;
      row.expected = {1'b0, expected};
      stimulus.push_back(row);
   endtask

   task automatic pixelRow(input int frame, input int line, input int col,
                           input ulaBusPkg::rgb_t expected);
      row_t row;
      row = '0;
      row.op = OpPixel;
      row.frame = frame;
      row.line = line;
      row.col = col;
      row.expected = expected;
      stimulus.push_back(row);
   endtask

   // Random kbd and EAR with issue 2 alternating
   task automatic keyboardReads(input logic micNow, input logic spkNow);
      int rnd;
      logic procEar;
      for (int k = 0; k < 4; k++) begin
         rnd = $random(seed);
         procEar = k[0] ? rnd[5] ^ (spkNow | micNow) : rnd[5] ^ spkNow;
         readRow({rnd[15:8], 8'hFE}, rnd[4:0], rnd[5], k[0], {1'b1, procEar, 1'b1, rnd[4:0]});
      end
   endtask

   task automatic buildStimulus();
      int xs [8];
      int rnd;
      row_t row;
      xs = '{0, 7, 13, 34, 66, 101, 130, 255};
      for (int i = 0; i < 64; i++) begin
         rnd = $random(seed);
         palModel[i] = rnd[7:0];
      end
      // Standard paper in frame 0 with flash cells uninverted
      foreach (xs[i]) pixelRow(0, 0, xs[i] + 13, expectPixel(0, xs[i], 1'b0, 0));
      foreach (xs[i]) pixelRow(0, 100, xs[i] + 13, expectPixel(100, xs[i], 1'b0, 0));
      // Border 5 with mic on
      writeRow(16'h00FE, 8'h0D, 9'b01);
      keyboardReads(1'b1, 1'b0);
      // ULAplus reset values
      readRow(PlusAddr, 5'h1F, 1'b0, 1'b0, 8'h00);
      writeRow(PlusAddr, 8'h40, 9'h0);
      readRow(PlusData, 5'h1F, 1'b0, 1'b0, 8'h00);
      readRow(PlusAddr, 5'h1F, 1'b0, 1'b0, 8'h40);
      pixelRow(0, 250, 100, stdColour(1'b0, 3'd5));
      // Border 4 with speaker on
      writeRow(16'h7FFE, 8'h14, 9'b10);
      keyboardReads(1'b0, 1'b1);
      pixelRow(1, 250, 100, stdColour(1'b0, 3'd4));
      // Whole palette with each entry read back
      for (int i = 0; i < 64; i++) begin
         writeRow(PlusAddr, i[7:0], 9'h0);
         writeRow(PlusData, palModel[i], 9'h0);
         readRow(PlusData, 5'h1F, 1'b0, 1'b0, palModel[i]);
         readRow(PlusAddr, 5'h1F, 1'b0, 1'b0, i[7:0]);
      end
      writeRow(PlusAddr, 8'h40, 9'h0);
      writeRow(PlusData, 8'h01, 9'h0);
      readRow(PlusData, 5'h1F, 1'b0, 1'b0, 8'h01);
      foreach (xs[i]) pixelRow(2, 0, xs[i] + 13, expectPixel(0, xs[i], 1'b1, 2));
      foreach (xs[i]) pixelRow(2, 100, xs[i] + 13, expectPixel(100, xs[i], 1'b1, 2));
      // Back to the standard palette
      writeRow(PlusData, 8'h00, 9'h0);
      readRow(PlusData, 5'h1F, 1'b0, 1'b0, 8'h00);
      row = '0;
      row.op = OpInterrupt;
      row.data = 8'd2;
      stimulus.push_back(row);
      // Flash phase set in frame 16
      foreach (xs[i]) pixelRow(16, 0, xs[i] + 13, expectPixel(0, xs[i], 1'b0, 16));
   endtask

   ////////////////////////////////////////////////////////////
   // Row execution
   ////////////////////////////////////////////////////////////

   function automatic ulaBusPkg::cpuBus_t busCycle(input logic [15:0] addr, input logic read,
                                                   input logic write, input logic [7:0] data);
      ulaBusPkg::cpuBus_t cycle;
      cycle.addr = addr;
      cycle.iorqN = !(read || write);
      cycle.rdN = !read;
      cycle.wrN = !write;
      cycle.data = data;
      return cycle;
   endfunction

   task automatic applyWrite(input row_t row);
      @(posedge clk7);
      bus <= busCycle(row.addr, 1'b0, 1'b1, row.data);
      @(posedge clk7);
      bus <= busCycle(16'hFFFF, 1'b0, 1'b0, 8'h00);
      @(negedge clk7);
      if (!row.addr[0]) begin
         assert ({spk, mic} == row.expected[1:0]) else begin
            $display("Error at %0d ns: spk/mic %b%b, expected %b", $time, spk, mic,
                     row.expected[1:0]);
            rowErrors++;
         end
      end
   endtask

   task automatic applyRead(input row_t row);
      @(posedge clk7);
      bus <= busCycle(row.addr, 1'b1, 1'b0, 8'h00);
      kbd <= row.kbd;
      ear <= row.ear;
      issue2Keyboard <= row.issue2;
      @(negedge clk7);
      assert (dout == row.expected[7:0]) else begin
         $display("Error at %0d ns: read %h gave %h, expected %h", $time, row.addr, dout,
                  row.expected[7:0]);
         rowErrors++;
      end
      @(posedge clk7);
      bus <= busCycle(16'hFFFF, 1'b0, 1'b0, 8'h00);
   endtask

   // Gives up once the wanted frame has gone by
   task automatic waitPosition(input int frame, input int line, input int col,
                               output bit reached);
      reached = 1'b0;
      while (!reached && frameCount <= frame) begin
         @(negedge clk7);
         reached = frameCount == frame && rasterVc == line && rasterHc == col;
      end
   endtask

   task automatic checkPixel(input row_t row);
      bit reached;
      waitPosition(row.frame, row.line, row.col, reached);
      if (!reached) begin
         $display("Raster position frame %0d line %0d hc %0d was missed", row.frame,
                  row.line, row.col);
         rowErrors++;
      end else begin
         assert (rgb == row.expected) else begin
            $display("Error at %0d ns: rgb %h at line %0d hc %0d, expected %h", $time, rgb,
                     row.line, row.col, row.expected);
            rowErrors++;
         end
      end
   endtask

   task automatic scanSyncAndInterrupt(input int frames);
      int lows;
      bit expectLow;
      bit hsyncNow;
      bit vsyncNow;
      lows = 0;
      repeat (frames * FrameCycles) begin
         @(negedge clk7);
         expectLow = rasterVc == IntLine && rasterHc >= IntStart && rasterHc <= IntEnd;
         hsyncNow = rasterHc >= HsyncStart && rasterHc <= HsyncEnd;
         vsyncNow = rasterVc >= VsyncStart && rasterVc <= VsyncEnd;
         if (!intN) lows++;
         assert (intN == !expectLow) else begin
            $display("Error at %0d ns: intN %b at line %0d hc %0d", $time, intN, rasterVc,
                     rasterHc);
            rowErrors++;
         end
         // Composite sync low on hsync and flipped over the vsync lines
         assert (csync == (vsyncNow ? hsyncNow : !hsyncNow)) else begin
            $display("Error at %0d ns: csync %b at line %0d hc %0d", $time, csync,
                     rasterVc, rasterHc);
            rowErrors++;
         end
      end
      assert (lows == frames * (IntEnd - IntStart + 1)) else begin
         $display("Error at %0d ns: intN low for %0d cycles", $time, lows);
         rowErrors++;
      end
   endtask

   function automatic string rowName(input row_t row);
      case (row.op)
         OpWrite: return $sformatf("write %h data %h", row.addr, row.data);
         OpRead: return $sformatf("read %h", row.addr);
         OpPixel: return $sformatf("pixel frame %0d line %0d hc %0d", row.frame, row.line,
                                   row.col);
         default: return $sformatf("interrupt and sync over %0d frames", row.data);
      endcase
   endfunction

   ////////////////////////////////////////////////////////////
   // Main sequence and watchdog
   ////////////////////////////////////////////////////////////

   initial begin
      clk7 = 1'b0;
      rst_n = 1'b0;
      bus = busCycle(16'hFFFF, 1'b0, 1'b0, 8'h00);
      ear = 1'b0;
      kbd = 5'h1F;
      issue2Keyboard = 1'b0;
      passCount = 0;
      failCount = 0;
      seed = 32'hd4ccc154;
      buildStimulus();
      repeat (2) @(posedge clk7);
      rst_n <= 1'b1;
      foreach (stimulus[i]) begin
         rowErrors = 0;
         case (stimulus[i].op)
            OpWrite: applyWrite(stimulus[i]);
            OpRead: applyRead(stimulus[i]);
            OpPixel: checkPixel(stimulus[i]);
            default: scanSyncAndInterrupt(stimulus[i].data);
         endcase
         if (rowErrors == 0) begin
            passCount++;
         end else begin
            failCount++;
         end
         $display("Test %0d %s %s", i, rowName(stimulus[i]), rowErrors == 0 ? "passed" : "failed");
      end
      $display("Tests %0d, passed %0d, failed %0d", stimulus.size(), passCount, failCount);
      if (failCount == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   initial begin
      #(WatchdogCycles * ClkPeriod);
      $display("Watchdog expired before all tests finished");
      $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/ulaTimingPkg.sv
logic/ulaBusPkg.sv
logic/rasterCounter.sv
logic/ioPorts.sv
logic/videoFetch.sv
logic/colourMapper.sv
logic/ulaCore.sv
test/ulaTb.sv

// ==== Bender.yml ====
package:
  name: ula_video_io

sources:
  - logic/ulaTimingPkg.sv
  - logic/ulaBusPkg.sv
  - logic/rasterCounter.sv
  - logic/ioPorts.sv
  - logic/videoFetch.sv
  - logic/colourMapper.sv
  - logic/ulaCore.sv
  - target: test
    files:
      - test/ulaTb.sv
